// ==== src/uart_alu_pkg.sv ====
package uart_alu_pkg;

   ////////////////////
   // Data types.
   ////////////////////

   // One UART byte. Also used for operands and results.
   typedef logic [7:0] data_t;

   // ALU function code, MIPS style.
   typedef logic [7:0] opcode_t;

   // Position within one bit period.
   typedef logic [3:0] tick_count_t;

   ////////////////////
   // Constants.
   ////////////////////

   localparam int OVERSAMPLE = 16;  // Ticks per bit.

   // Function codes.
   localparam opcode_t OP_ADD = 8'h20;
   localparam opcode_t OP_SUB = 8'h22;
   localparam opcode_t OP_AND = 8'h24;
   localparam opcode_t OP_OR  = 8'h25;
   localparam opcode_t OP_XOR = 8'h26;
   localparam opcode_t OP_NOR = 8'h27;
   localparam opcode_t OP_SRA = 8'h03;  // Arithmetic shift right.
   localparam opcode_t OP_SRL = 8'h02;  // Logical shift right.

endpackage

// ==== src/baud_rate_generator.sv ====
module baud_rate_generator #(
   parameter int BAUD_DIVISOR = 4
) (
   input  logic i_clock,
   input  logic i_reset,
   output logic o_tick
);

   localparam int COUNT_WIDTH = $clog2(BAUD_DIVISOR);
   localparam logic [COUNT_WIDTH-1:0] COUNT_TOP = COUNT_WIDTH'(BAUD_DIVISOR - 1);

   logic [COUNT_WIDTH-1:0] count;  // Cycles left until the next tick.

   always_ff @(posedge i_clock) begin
      if (!i_reset) begin
         count  <= COUNT_TOP;
         o_tick <= 1'b0;
      end else if (count == '0) begin
         // Wrap and fire.
         count  <= COUNT_TOP;
         o_tick <= 1'b1;
      end else begin
         count  <= count - 1'b1;
         o_tick <= 1'b0;
      end
   end

endmodule

// ==== src/uart_receiver.sv ====
module uart_receiver (
   input  logic                i_clock,
   input  logic                i_reset,
   input  logic                i_tick,
   input  logic                i_rx_serial,
   output uart_alu_pkg::data_t o_rx_data,
   output logic                o_rx_done
);

   import uart_alu_pkg::*;

   typedef enum logic [1:0] {
      idle,
      start_bit,
      data_bits,
      stop_bit
   } rx_state_t;

   localparam tick_count_t MID_TICK  = tick_count_t'(OVERSAMPLE / 2 - 1);
   localparam tick_count_t LAST_TICK = tick_count_t'(OVERSAMPLE - 1);

   rx_state_t   state;
   tick_count_t tick_count;
   logic [2:0]  bit_count;   // Data bit index.
   data_t       shift_reg;
   logic        rx_meta;
   logic        rx_sync;
   logic        rx_prev;
   logic        rx_fall;
   logic        bit_end;     // Middle of a data or stop bit.

   ////////////////////
   // Input sync.
   ////////////////////

   always_ff @(posedge i_clock) begin
      if (!i_reset) begin
         rx_meta <= 1'b1;  // Idle line is high.
         rx_sync <= 1'b1;
         rx_prev <= 1'b1;
      end else begin
         rx_meta <= i_rx_serial;
         rx_sync <= rx_meta;
         rx_prev <= rx_sync;
      end
   end

   assign rx_fall = rx_prev & ~rx_sync;
   assign bit_end = i_tick && (tick_count == LAST_TICK);

   ////////////////////
   // Frame FSM.
   ////////////////////

   always_ff @(posedge i_clock) begin
      if (!i_reset) begin
         state      <= idle;
         tick_count <= '0;
         bit_count  <= '0;
         o_rx_done  <= 1'b0;
      end else begin
         case (state)
            idle: begin
               if (rx_fall) begin
                  state      <= start_bit;
                  tick_count <= '0;
                  o_rx_done  <= 1'b0;  // Previous byte is released here.
               end
            end
            start_bit: begin
               if (i_tick) begin
                  if (tick_count == MID_TICK) begin
                     // Still low at mid bit, so a real start.
                     tick_count <= '0;
                     bit_count  <= '0;
                     state      <= rx_sync ? idle : data_bits;
                  end else begin
                     tick_count <= tick_count + 1'b1;
                  end
               end
            end
            data_bits: begin
               if (i_tick) begin
                  tick_count <= tick_count + 1'b1;  // Wraps to zero at the bit end.
               end
               if (bit_end) begin
                  bit_count <= bit_count + 1'b1;
                  if (bit_count == 3'd7) begin
                     state <= stop_bit;
                  end
               end
            end
            stop_bit: begin
               if (i_tick) begin
                  tick_count <= tick_count + 1'b1;
               end
               if (bit_end) begin
                  state     <= idle;    // Ready for a start bit right away.
                  o_rx_done <= rx_sync;  // Low stop bit drops the frame.
               end
            end
            default: begin
               state <= idle;
            end
         endcase
      end
   end

   // Byte assembly, LSB first.
   always_ff @(posedge i_clock) begin
      if (state == data_bits && bit_end) begin
         shift_reg <= {rx_sync, shift_reg[7:1]};
      end
      if (state == stop_bit && bit_end && rx_sync) begin
         o_rx_data <= shift_reg;
      end
   end

endmodule

// ==== src/uart_transmitter.sv ====
module uart_transmitter (
   input  logic                i_clock,
   input  logic                i_reset,
   input  logic                i_tick,
   input  logic                i_tx_start,
   input  uart_alu_pkg::data_t i_tx_data,
   output logic                o_tx_serial,
   output logic                o_tx_done
);

   import uart_alu_pkg::*;

   typedef enum logic [1:0] {
      idle,
      start_bit,
      data_bits,
      stop_bit
   } tx_state_t;

   localparam tick_count_t LAST_TICK = tick_count_t'(OVERSAMPLE - 1);

   tx_state_t   state;
   tick_count_t tick_count;
   logic [2:0]  bit_count;
   data_t       shift_reg;  // Bits still to send, next one at bit 0.
   logic        bit_end;

   assign bit_end = i_tick && (tick_count == LAST_TICK);

   // Bit timer, held at zero while idle.
   always_ff @(posedge i_clock) begin
      if (!i_reset) begin
         tick_count <= '0;
      end else if (state == idle) begin
         tick_count <= '0;
      end else if (i_tick) begin
         tick_count <= tick_count + 1'b1;
      end
   end

   ////////////////////
   // Frame FSM.
   ////////////////////

   always_ff @(posedge i_clock) begin
      if (!i_reset) begin
         state       <= idle;
         bit_count   <= '0;
         o_tx_serial <= 1'b1;
         o_tx_done   <= 1'b0;
      end else begin
         o_tx_done <= 1'b0;
         case (state)
            idle: begin
               if (i_tx_start) begin
                  state       <= start_bit;
                  o_tx_serial <= 1'b0;  // Start bit.
               end
            end
            start_bit: begin
               if (bit_end) begin
                  state       <= data_bits;
                  bit_count   <= '0;
                  o_tx_serial <= shift_reg[0];
               end
            end
            data_bits: begin
               if (bit_end) begin
                  bit_count <= bit_count + 1'b1;
                  if (bit_count == 3'd7) begin
                     state       <= stop_bit;
                     o_tx_serial <= 1'b1;
                  end else begin
                     o_tx_serial <= shift_reg[1];
                  end
               end
            end
            stop_bit: begin
               if (bit_end) begin
                  state     <= idle;
                  o_tx_done <= 1'b1;  // One cycle only.
               end
            end
            default: begin
               state <= idle;
            end
         endcase
      end
   end

   // Payload latch and shift.
   always_ff @(posedge i_clock) begin
      if (state == idle && i_tx_start) begin
         shift_reg <= i_tx_data;
      end else if (state == data_bits && bit_end) begin
         shift_reg <= shift_reg >> 1;
      end
   end

endmodule

// ==== src/alu.sv ====
module alu (
   input  uart_alu_pkg::data_t   i_operand_a,
   input  uart_alu_pkg::data_t   i_operand_b,
   input  uart_alu_pkg::opcode_t i_opcode,
   output uart_alu_pkg::data_t   o_result
);

   import uart_alu_pkg::*;

   logic [2:0] shift_amount;

   // Only the low three bits of B matter for shifts.
   assign shift_amount = i_operand_b[2:0];

   always_comb begin
      case (i_opcode)
         OP_ADD: begin
            o_result = i_operand_a + i_operand_b;  // Modulo 256.
         end
         OP_SUB: begin
            o_result = i_operand_a - i_operand_b;
         end
         OP_AND: begin
            o_result = i_operand_a & i_operand_b;
         end
         OP_OR: begin
            o_result = i_operand_a | i_operand_b;
         end
         OP_XOR: begin
            o_result = i_operand_a ^ i_operand_b;
         end
         OP_NOR: begin
            o_result = ~(i_operand_a | i_operand_b);
         end
         OP_SRA: begin
            o_result = data_t'($signed(i_operand_a) >>> shift_amount);  // Sign fill.
         end
         OP_SRL: begin
            o_result = i_operand_a >> shift_amount;
         end
         default: begin
            o_result = '0;  // Undefined opcode.
         end
      endcase
   end

endmodule

// ==== src/interface_circuit.sv ====
module interface_circuit (
   input  logic                  i_clock,
   input  logic                  i_reset,
   input  uart_alu_pkg::data_t   i_rx_data,
   input  logic                  i_rx_done,
   input  logic                  i_tx_done,
   input  uart_alu_pkg::data_t   i_alu_result,
   output uart_alu_pkg::data_t   o_reg_operand_a,
   output uart_alu_pkg::data_t   o_reg_operand_b,
   output uart_alu_pkg::opcode_t o_reg_opcode,
   output uart_alu_pkg::data_t   o_tx_data,
   output logic                  o_tx_start
);

   import uart_alu_pkg::*;

   typedef enum logic [2:0] {
      wait_operand_a,
      wait_opcode,
      wait_operand_b,
      load_result,
      start_tx,
      wait_tx_done
   } state_t;

   state_t  state;
   state_t  next_state;
   logic    rx_done_q;  // Previous rx_done, for edge detection.
   logic    tx_done_q;
   logic    rx_edge;
   logic    tx_edge;
   data_t   operand_a_next;
   data_t   operand_b_next;
   opcode_t opcode_next;
   data_t   tx_data_next;

   assign rx_edge = i_rx_done & ~rx_done_q;
   assign tx_edge = i_tx_done & ~tx_done_q;

   ////////////////////
   // Registers.
   ////////////////////

   always_ff @(posedge i_clock) begin
      if (!i_reset) begin
         state           <= wait_operand_a;
         rx_done_q       <= 1'b0;
         tx_done_q       <= 1'b0;
         o_reg_operand_a <= '0;
         o_reg_operand_b <= '0;
         o_reg_opcode    <= '0;
         o_tx_data       <= '0;
      end else begin
         state           <= next_state;
         rx_done_q       <= i_rx_done;
         tx_done_q       <= i_tx_done;
         o_reg_operand_a <= operand_a_next;
         o_reg_operand_b <= operand_b_next;
         o_reg_opcode    <= opcode_next;
         o_tx_data       <= tx_data_next;
      end
   end

   ////////////////////
   // Next state.
   ////////////////////

   always_comb begin
      next_state     = state;
      operand_a_next = o_reg_operand_a;
      operand_b_next = o_reg_operand_b;
      opcode_next    = o_reg_opcode;
      tx_data_next   = o_tx_data;
      case (state)
         wait_operand_a: begin
            if (rx_edge) begin
               operand_a_next = i_rx_data;
               next_state     = wait_opcode;
            end
         end
         wait_opcode: begin
            if (rx_edge) begin
               opcode_next = i_rx_data;
               next_state  = wait_operand_b;
            end
         end
         wait_operand_b: begin
            if (rx_edge) begin
               operand_b_next = i_rx_data;
               next_state     = load_result;
            end
         end
         load_result: begin
            // ALU already sees the new B here.
            tx_data_next = i_alu_result;
            next_state   = start_tx;
         end
         start_tx: begin
            next_state = wait_tx_done;
         end
         wait_tx_done: begin
            // Incoming bytes are dropped until the result is out.
            if (tx_edge) begin
               next_state = wait_operand_a;
            end
         end
         default: begin
            next_state = wait_operand_a;
         end
      endcase
   end

   assign o_tx_start = (state == start_tx);  // Single cycle pulse.

endmodule

// ==== src/uart_alu_top.sv ====
module uart_alu_top #(
   parameter int BAUD_DIVISOR = 4
) (
   input  logic i_clock,
   input  logic i_reset,
   input  logic i_rx_serial,
   output logic o_tx_serial
);

   import uart_alu_pkg::*;

   logic    tick;
   data_t   rx_data;
   logic    rx_done;
   data_t   reg_operand_a;
   data_t   reg_operand_b;
   opcode_t reg_opcode;
   data_t   alu_result;
   data_t   tx_data;
   logic    tx_start;
   logic    tx_done;

   // Shared oversampling time base.
   baud_rate_generator #(
      .BAUD_DIVISOR (BAUD_DIVISOR)
   ) i_baud_rate_generator (
      .i_clock (i_clock),
      .i_reset (i_reset),
      .o_tick  (tick)
   );

   uart_receiver i_uart_receiver (
      .i_clock     (i_clock),
      .i_reset     (i_reset),
      .i_tick      (tick),
      .i_rx_serial (i_rx_serial),
      .o_rx_data   (rx_data),
      .o_rx_done   (rx_done)
   );

   interface_circuit i_interface_circuit (
      .i_clock         (i_clock),
      .i_reset         (i_reset),
      .i_rx_data       (rx_data),
      .i_rx_done       (rx_done),
      .i_tx_done       (tx_done),
      .i_alu_result    (alu_result),
      .o_reg_operand_a (reg_operand_a),
      .o_reg_operand_b (reg_operand_b),
      .o_reg_opcode    (reg_opcode),
      .o_tx_data       (tx_data),
      .o_tx_start      (tx_start)
   );

   alu i_alu (
      .i_operand_a (reg_operand_a),
      .i_operand_b (reg_operand_b),
      .i_opcode    (reg_opcode),
      .o_result    (alu_result)
   );

   uart_transmitter i_uart_transmitter (
      .i_clock     (i_clock),
      .i_reset     (i_reset),
      .i_tick      (tick),
      .i_tx_start  (tx_start),
      .i_tx_data   (tx_data),
      .o_tx_serial (o_tx_serial),
      .o_tx_done   (tx_done)
   );

endmodule

// ==== tb/tb_uart_alu_top.sv ====
module tb_uart_alu_top;

   localparam int BAUD_DIVISOR  = 4;
   localparam int BIT_CYCLES    = 64;              // 16 ticks of 4 clocks.
   localparam int HALF_BIT      = BIT_CYCLES / 2;
   localparam int START_TIMEOUT = 3000;            // Covers three request frames.

   // ALU function codes.
   localparam logic [7:0] OP_ADD = 8'h20;
   localparam logic [7:0] OP_SUB = 8'h22;
   localparam logic [7:0] OP_AND = 8'h24;
   localparam logic [7:0] OP_OR  = 8'h25;
   localparam logic [7:0] OP_XOR = 8'h26;
   localparam logic [7:0] OP_NOR = 8'h27;
   localparam logic [7:0] OP_SRA = 8'h03;
   localparam logic [7:0] OP_SRL = 8'h02;

   logic i_clock;
   logic i_reset;
   logic i_rx_serial;
   logic o_tx_serial;

   int value_errors;
   int other_errors;

   uart_alu_top #(
      .BAUD_DIVISOR (BAUD_DIVISOR)
   ) i_uart_alu_top (
      .i_clock     (i_clock),
      .i_reset     (i_reset),
      .i_rx_serial (i_rx_serial),
      .o_tx_serial (o_tx_serial)
   );

   always #5 i_clock = ~i_clock;

   ////////////////////
   // Reference model.
   ////////////////////

   function automatic logic [7:0] ref_result(input logic [7:0] a, input logic [7:0] op,
                                             input logic [7:0] b);
      logic [15:0] sign_ext;
      logic [2:0]  shift;
      shift    = b[2:0];
      sign_ext = {{8{a[7]}}, a};  // Upper byte carries the sign for SRA.
      case (op)
         OP_ADD: ref_result = 8'(a + b);
         OP_SUB: ref_result = 8'(a - b);
         OP_AND: ref_result = a & b;
         OP_OR:  ref_result = a | b;
         OP_XOR: ref_result = a ^ b;
         OP_NOR: ref_result = ~(a | b);
         OP_SRA: begin
            sign_ext   = sign_ext >> shift;
            ref_result = sign_ext[7:0];
         end
         OP_SRL:  ref_result = a >> shift;
         default: ref_result = 8'h00;
      endcase
   endfunction

   function automatic logic [7:0] opcode_at(input int index);
      case (index)
         0:       opcode_at = OP_ADD;
         1:       opcode_at = OP_SUB;
         2:       opcode_at = OP_AND;
         3:       opcode_at = OP_OR;
         4:       opcode_at = OP_XOR;
         5:       opcode_at = OP_NOR;
         6:       opcode_at = OP_SRA;
         default: opcode_at = OP_SRL;
      endcase
   endfunction

   ////////////////////
   // Serial host.
   ////////////////////

   // Ends one time unit after a rising edge.
   task automatic wait_cycles(input int count);
      repeat (count) @(posedge i_clock);
      #1;
   endtask

   task automatic send_frame(input logic [7:0] data, input logic stop_value);
      i_rx_serial = 1'b0;
      wait_cycles(BIT_CYCLES);
      for (int i = 0; i < 8; i++) begin
         i_rx_serial = data[i];  // LSB first.
         wait_cycles(BIT_CYCLES);
      end
      i_rx_serial = stop_value;
      wait_cycles(BIT_CYCLES);
      i_rx_serial = 1'b1;
   endtask

   task automatic receive_frame(output logic [7:0] data, output logic received);
      int waited;
      waited   = 0;
      data     = 8'h00;
      received = 1'b0;
      while (o_tx_serial !== 1'b0 && waited < START_TIMEOUT) begin
         wait_cycles(1);
         waited++;
      end
      assert (o_tx_serial === 1'b0) else begin
         other_errors++;
         $display("Timed out after %0d cycles waiting for a result start bit.", waited);
      end
      if (o_tx_serial === 1'b0) begin
         wait_cycles(HALF_BIT);  // Middle of the start bit.
         assert (o_tx_serial === 1'b0) else begin
            other_errors++;
            $display("Result start bit went high before its middle.");
         end
         for (int i = 0; i < 8; i++) begin
            wait_cycles(BIT_CYCLES);
            data[i] = o_tx_serial;
         end
         wait_cycles(BIT_CYCLES);
         assert (o_tx_serial === 1'b1) else begin
            other_errors++;
            $display("Stop bit of the result frame is low.");
         end
         wait_cycles(HALF_BIT);  // Out to the end of the frame.
         received = 1'b1;
      end
   endtask

   // Sends A, opcode and B while watching the transmit line.
   task automatic run_command(input logic [7:0] a, input logic [7:0] op,
                              input logic [7:0] b);
      logic [7:0] expected;
      logic [7:0] got;
      logic       received;
      expected = ref_result(a, op, b);
      fork
         begin
            send_frame(a, 1'b1);
            send_frame(op, 1'b1);
            send_frame(b, 1'b1);
         end
         receive_frame(got, received);
      join
      if (received) begin
         assert (got === expected) else begin
            value_errors++;
            $display("** Error: o_tx_serial (A 0x%h, op 0x%h, B 0x%h) expected 0x%h, got 0x%h",
                     a, op, b, expected, got);
         end
      end
   endtask

   task automatic check_idle_line(input int cycles);
      logic seen_low;
      seen_low = 1'b0;
      for (int i = 0; i < cycles && !seen_low; i++) begin
         wait_cycles(1);
         assert (o_tx_serial === 1'b1) else begin
            value_errors++;
            $display("** Error: o_tx_serial while idle expected 0x1, got 0x%h", o_tx_serial);
            seen_low = 1'b1;
         end
      end
   endtask

   ////////////////////
   // Main sequence.
   ////////////////////

   initial begin
      logic [7:0] a;
      logic [7:0] b;
      value_errors = 0;
      other_errors = 0;
      i_clock      = 1'b0;
      i_reset      = 1'b0;
      i_rx_serial  = 1'b1;
      void'($urandom(12));
      wait_cycles(8);
      i_reset = 1'b1;

      check_idle_line(500);

      // Every opcode twice. The second pass forces A negative for the shifts.
      for (int pass = 0; pass < 2; pass++) begin
         for (int k = 0; k < 8; k++) begin
            a = 8'($urandom);
            b = 8'($urandom);
            if (pass == 1) begin
               a[7] = 1'b1;
            end
            run_command(a, opcode_at(k), b);
         end
      end

      run_command(8'($urandom), 8'h55, 8'($urandom));  // Undefined opcode.

      // Second command follows the first result with no gap.
      run_command(8'($urandom), OP_SUB, 8'($urandom));
      run_command(8'($urandom), OP_XOR, 8'($urandom));

      // Broken frame as A followed by a clean command.
      send_frame(8'hA5, 1'b0);
      wait_cycles(BIT_CYCLES);
      run_command(8'h3C, OP_ADD, 8'h11);

      $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== uart_alu_top.f ====
src/uart_alu_pkg.sv
src/baud_rate_generator.sv
src/uart_receiver.sv
src/uart_transmitter.sv
src/alu.sv
src/interface_circuit.sv
src/uart_alu_top.sv
tb/tb_uart_alu_top.sv
